// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_dcache and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_dcache -f flist.f -Mdir obj_dir
	./obj_dir/Vtb_dcache | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== flist.f ====
+incdir+include
source/dcache_addr_pkg.sv
source/dcache_ctrl_pkg.sv
source/dcache_ram.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_ctrl.sv
source/dcache_top.sv
test/tb_clock_gen.sv
test/tb_dcache.sv

// ==== include/dcache_params.svh ====
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Address split is tag, index, word select, then two byte bits
`define DC_ADDR_W      32
`define DC_TAG_W       20
`define DC_INDEX_W     7
`define DC_WORD_SEL_W  3

// Geometry
`define DC_WAYS        2
`define DC_SETS        128
`define DC_LINE_WORDS  8

`endif

// ==== source/dcache_addr_pkg.sv ====
`include "dcache_params.svh"

package dcache_addr_pkg;

   typedef logic [`DC_ADDR_W-1:0]     addr_t;
   typedef logic [`DC_TAG_W-1:0]      tag_t;
   typedef logic [`DC_INDEX_W-1:0]    index_t;
   typedef logic [`DC_WORD_SEL_W-1:0] word_sel_t;
   typedef logic [31:0]               word_t;
   typedef logic [3:0]                byte_en_t;
   typedef logic [`DC_WAYS-1:0]       way_oh_t;

   function automatic tag_t addr_tag(addr_t addr);
      return addr[`DC_ADDR_W-1 -: `DC_TAG_W];
   endfunction

   function automatic index_t addr_index(addr_t addr);
      return addr[`DC_WORD_SEL_W+2 +: `DC_INDEX_W];
   endfunction

   function automatic word_sel_t addr_word(addr_t addr);
      return addr[2 +: `DC_WORD_SEL_W];
   endfunction

   // First byte of a line, where every burst starts
   function automatic addr_t line_addr(tag_t tag, index_t index);
      return {tag, index, {(`DC_WORD_SEL_W + 2){1'b0}}};
   endfunction

endpackage

// ==== source/dcache_ctrl.sv ====
`include "dcache_params.svh"

module dcache_ctrl (
   input  logic                       clk,
   input  logic                       reset,
   // CPU
   input  logic                       i_req_valid,
   input  logic                       i_req_write,
   input  dcache_addr_pkg::addr_t     i_req_addr,
   input  dcache_addr_pkg::word_t     i_req_wdata,
   input  dcache_addr_pkg::byte_en_t  i_req_byte_en,
   output logic                       o_req_ready,
   output logic                       o_resp_valid,
   output dcache_addr_pkg::word_t     o_resp_rdata,
   // Memory
   output logic                       o_ar_valid,
   input  logic                       i_ar_ready,
   output dcache_addr_pkg::addr_t     o_ar_addr,
   input  logic                       i_r_valid,
   output logic                       o_r_ready,
   input  dcache_addr_pkg::word_t     i_r_data,
   input  logic                       i_r_last,
   output logic                       o_aw_valid,
   input  logic                       i_aw_ready,
   output dcache_addr_pkg::addr_t     o_aw_addr,
   output logic                       o_w_valid,
   input  logic                       i_w_ready,
   output dcache_addr_pkg::word_t     o_w_data,
   output logic                       o_w_last,
   input  logic                       i_b_valid,
   output logic                       o_b_ready,
   // Tag and data stores
   output dcache_addr_pkg::index_t    o_lookup_index,
   output dcache_addr_pkg::tag_t      o_lookup_tag,
   input  dcache_addr_pkg::way_oh_t   i_hit_way,
   input  dcache_addr_pkg::way_oh_t   i_victim_way,
   input  logic                       i_victim_dirty,
   input  dcache_addr_pkg::tag_t      i_victim_tag,
   input  dcache_addr_pkg::word_t     i_store_rdata,
   output logic                       o_touch,
   output dcache_addr_pkg::way_oh_t   o_touch_way,
   output logic                       o_set_dirty,
   output logic                       o_fill,
   output dcache_addr_pkg::way_oh_t   o_data_way,
   output dcache_addr_pkg::word_sel_t o_word_sel,
   output logic                       o_data_we,
   output dcache_addr_pkg::byte_en_t  o_byte_en,
   output dcache_addr_pkg::word_t     o_data_wdata
);

   import dcache_addr_pkg::*;
   import dcache_ctrl_pkg::*;

   ctrl_state_t state;
   word_sel_t   beat;
   logic        fill_done;
   logic        req_write;
   addr_t       req_addr;
   word_t       req_wdata;
   byte_en_t    req_byte_en;
   logic        hit;
   logic        w_fire;
   logic        r_fire;

   assign hit    = |i_hit_way;
   assign w_fire = o_w_valid && i_w_ready;
   assign r_fire = o_r_ready && i_r_valid;

   //////////////////////////////////////////////////
   // CPU and memory ports

   assign o_req_ready  = state == IDLE;
   assign o_resp_valid = state == LOOKUP && hit;
   assign o_resp_rdata = i_store_rdata;

   // Victim tag and LRU hold still while the set is not written
   assign o_aw_valid = state == WB_ADDR;
   assign o_aw_addr  = line_addr(i_victim_tag, addr_index(req_addr));
   assign o_w_valid  = state == WB_DATA;
   assign o_w_data   = i_store_rdata;
   assign o_w_last   = beat == word_sel_t'(`DC_LINE_WORDS - 1);
   assign o_b_ready  = state == WB_RESP;
   assign o_ar_valid = state == FILL_ADDR;
   assign o_ar_addr  = line_addr(addr_tag(req_addr), addr_index(req_addr));
   assign o_r_ready  = state == FILL_DATA && !fill_done;

   //////////////////////////////////////////////////
   // Store commands

   // In IDLE the stores read ahead with the incoming address
   assign o_lookup_index = (state == IDLE) ? addr_index(i_req_addr) : addr_index(req_addr);
   assign o_lookup_tag   = (state == IDLE) ? addr_tag(i_req_addr) : addr_tag(req_addr);

   assign o_touch      = o_resp_valid;
   assign o_touch_way  = i_hit_way;
   assign o_set_dirty  = o_resp_valid && req_write;
   assign o_fill       = r_fire && i_r_last;
   assign o_data_way   = (state == LOOKUP) ? i_hit_way : i_victim_way;
   assign o_data_we    = o_set_dirty || r_fire;
   assign o_byte_en    = (state == LOOKUP) ? req_byte_en : '1;
   assign o_data_wdata = (state == LOOKUP) ? req_wdata : i_r_data;

   always_comb begin
      case (state)
         IDLE:      o_word_sel = addr_word(i_req_addr);
         LOOKUP:    o_word_sel = addr_word(req_addr);
         // Next word is fetched only as the current one leaves
         WB_DATA:   o_word_sel = beat + word_sel_t'(w_fire);
         // Spare cycle after the last beat reads the requested word back
         FILL_DATA: o_word_sel = fill_done ? addr_word(req_addr) : beat;
         default:   o_word_sel = beat;
      endcase
   end

   //////////////////////////////////////////////////
   // Request register and FSM

   always_ff @(posedge clk) begin
      if (o_req_ready && i_req_valid) begin
         req_write   <= i_req_write;
         req_addr    <= i_req_addr;
         req_wdata   <= i_req_wdata;
         req_byte_en <= i_req_byte_en;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= IDLE;
         beat      <= '0;
         fill_done <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (i_req_valid) begin
                  state <= LOOKUP;
               end
            end
            LOOKUP: begin
               beat <= '0;
               if (hit) begin
                  state <= IDLE;
               end else if (i_victim_dirty) begin
                  state <= WB_ADDR;
               end else begin
                  state <= FILL_ADDR;
               end
            end
            WB_ADDR: begin
               if (i_aw_ready) begin
                  state <= WB_DATA;
               end
            end
            WB_DATA: begin
               if (w_fire) begin
                  beat <= beat + 1'b1;
                  if (o_w_last) begin
                     state <= WB_RESP;
                  end
               end
            end
            WB_RESP: begin
               if (i_b_valid) begin
                  state <= FILL_ADDR;
               end
            end
            FILL_ADDR: begin
               if (i_ar_ready) begin
                  state <= FILL_DATA;
               end
            end
            FILL_DATA: begin
               if (fill_done) begin
                  fill_done <= 1'b0;
                  state     <= LOOKUP;
               end else if (r_fire) begin
                  beat      <= beat + 1'b1;
                  fill_done <= i_r_last;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (reset)
      o_ar_valid && !i_ar_ready |=> o_ar_valid);
   assert property (@(posedge clk) disable iff (reset)
      o_aw_valid && !i_aw_ready |=> o_aw_valid);
   assert property (@(posedge clk) disable iff (reset)
      state inside {IDLE, LOOKUP, WB_ADDR, WB_DATA, WB_RESP, FILL_ADDR, FILL_DATA});

endmodule

// ==== source/dcache_ctrl_pkg.sv ====
package dcache_ctrl_pkg;

   import dcache_addr_pkg::*;

   // One tag RAM entry; valid and dirty sit in flops beside it
   typedef struct packed {
      tag_t tag;
   } tag_entry_t;

   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      WB_ADDR,
      WB_DATA,
      WB_RESP,
      FILL_ADDR,
      FILL_DATA
   } ctrl_state_t;

endpackage

// ==== source/dcache_data_store.sv ====
`include "dcache_params.svh"

module dcache_data_store (
   input  logic                       clk,
   input  dcache_addr_pkg::way_oh_t   i_way,
   input  dcache_addr_pkg::index_t    i_index,
   input  dcache_addr_pkg::word_sel_t i_word_sel,
   input  logic                       i_we,
   input  dcache_addr_pkg::byte_en_t  i_byte_en,
   input  dcache_addr_pkg::word_t     i_wdata,
   output dcache_addr_pkg::word_t     o_rdata
);

   import dcache_addr_pkg::*;

   localparam int words = `DC_SETS * `DC_LINE_WORDS;

   logic [$clog2(words)-1:0] addr;
   word_t                    rd_word [`DC_WAYS];
   word_t                    merged;

   assign addr = {i_index, i_word_sel};

   for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
      dcache_ram #(
         .entry_t (word_t),
         .depth   (words)
      ) u_data_ram (
         .clk     (clk),
         .i_we    (i_we && i_way[w]),
         .i_waddr (addr),
         .i_wdata (merged),
         .i_raddr (addr),
         .o_rdata (rd_word[w])
      );
   end

   // Way select is one-hot, so an OR of the gated words is enough
   always_comb begin
      o_rdata = '0;
      for (int w = 0; w < `DC_WAYS; w++) begin
         if (i_way[w]) begin
            o_rdata |= rd_word[w];
         end
      end
   end

   // Old bytes come from the word read at this same address a cycle earlier
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merged[8*b +: 8] = i_byte_en[b] ? i_wdata[8*b +: 8] : o_rdata[8*b +: 8];
      end
   end

   assert property (@(posedge clk) i_we |-> $onehot(i_way));

endmodule

// ==== source/dcache_ram.sv ====
module dcache_ram #(
   parameter type entry_t = logic [31:0],
   parameter int  depth   = 128
) (
   input  logic                     clk,
   input  logic                     i_we,
   input  logic [$clog2(depth)-1:0] i_waddr,
   input  entry_t                   i_wdata,
   input  logic [$clog2(depth)-1:0] i_raddr,
   output entry_t                   o_rdata
);

   entry_t mem [depth];

   always_ff @(posedge clk) begin
      if (i_we) begin
         mem[i_waddr] <= i_wdata;
      end
      // Write-first, so a read of the address being written sees the new entry
      if (i_we && i_waddr == i_raddr) begin
         o_rdata <= i_wdata;
      end else begin
         o_rdata <= mem[i_raddr];
      end
   end

endmodule

// ==== source/dcache_tag_store.sv ====
`include "dcache_params.svh"

module dcache_tag_store (
   input  logic                     clk,
   input  logic                     reset,
   input  dcache_addr_pkg::index_t  i_index,
   input  dcache_addr_pkg::tag_t    i_tag,
   input  logic                     i_touch,
   input  dcache_addr_pkg::way_oh_t i_touch_way,
   input  logic                     i_set_dirty,
   input  logic                     i_fill,
   output dcache_addr_pkg::way_oh_t o_hit_way,
   output dcache_addr_pkg::way_oh_t o_victim_way,
   output logic                     o_victim_dirty,
   output dcache_addr_pkg::tag_t    o_victim_tag
);

   import dcache_addr_pkg::*;
   import dcache_ctrl_pkg::*;

   index_t              index_q;
   tag_t                tag_q;
   tag_entry_t          entry   [`DC_WAYS];
   logic [`DC_SETS-1:0] valid_q [`DC_WAYS];
   logic [`DC_SETS-1:0] dirty_q [`DC_WAYS];
   // Number of the least recently used way, per set
   logic [`DC_SETS-1:0] lru_q;

   // Lookup key lines up with the registered RAM output
   always_ff @(posedge clk) begin
      index_q <= i_index;
      tag_q   <= i_tag;
   end

   for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
      dcache_ram #(
         .entry_t (tag_entry_t),
         .depth   (`DC_SETS)
      ) u_tag_ram (
         .clk     (clk),
         .i_we    (i_fill && o_victim_way[w]),
         .i_waddr (index_q),
         .i_wdata (tag_entry_t'(tag_q)),
         .i_raddr (i_index),
         .o_rdata (entry[w])
      );

      assign o_hit_way[w] = valid_q[w][index_q] && entry[w].tag == tag_q;
   end

   assign o_victim_way   = way_oh_t'(1) << lru_q[index_q];
   assign o_victim_dirty = dirty_q[lru_q[index_q]][index_q];
   assign o_victim_tag   = entry[lru_q[index_q]].tag;

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int w = 0; w < `DC_WAYS; w++) begin
            valid_q[w] <= '0;
            dirty_q[w] <= '0;
         end
         lru_q <= '0;
      end else if (i_fill) begin
         // New line is clean, and the other way becomes the victim
         valid_q[lru_q[index_q]][index_q] <= 1'b1;
         dirty_q[lru_q[index_q]][index_q] <= 1'b0;
         lru_q[index_q]                   <= ~lru_q[index_q];
      end else begin
         if (i_touch) begin
            lru_q[index_q] <= i_touch_way[0];
         end
         for (int w = 0; w < `DC_WAYS; w++) begin
            if (i_set_dirty && o_hit_way[w]) begin
               dirty_q[w][index_q] <= 1'b1;
            end
         end
      end
   end

   // A line is only ever filled into a set after both ways missed
   assert property (@(posedge clk) disable iff (reset) !(&o_hit_way));

endmodule

// ==== source/dcache_top.sv ====
module dcache_top (
   input  logic                      clk,
   input  logic                      reset,
   // CPU
   input  logic                      i_req_valid,
   input  logic                      i_req_write,
   input  dcache_addr_pkg::addr_t    i_req_addr,
   input  dcache_addr_pkg::word_t    i_req_wdata,
   input  dcache_addr_pkg::byte_en_t i_req_byte_en,
   output logic                      o_req_ready,
   output logic                      o_resp_valid,
   output dcache_addr_pkg::word_t    o_resp_rdata,
   // Memory
   output logic                      o_ar_valid,
   input  logic                      i_ar_ready,
   output dcache_addr_pkg::addr_t    o_ar_addr,
   input  logic                      i_r_valid,
   output logic                      o_r_ready,
   input  dcache_addr_pkg::word_t    i_r_data,
   input  logic                      i_r_last,
   output logic                      o_aw_valid,
   input  logic                      i_aw_ready,
   output dcache_addr_pkg::addr_t    o_aw_addr,
   output logic                      o_w_valid,
   input  logic                      i_w_ready,
   output dcache_addr_pkg::word_t    o_w_data,
   output logic                      o_w_last,
   input  logic                      i_b_valid,
   output logic                      o_b_ready
);

   import dcache_addr_pkg::*;

   index_t    lookup_index;
   tag_t      lookup_tag;
   way_oh_t   hit_way;
   way_oh_t   victim_way;
   logic      victim_dirty;
   tag_t      victim_tag;
   word_t     store_rdata;
   logic      touch;
   way_oh_t   touch_way;
   logic      set_dirty;
   logic      fill;
   way_oh_t   data_way;
   word_sel_t word_sel;
   logic      data_we;
   byte_en_t  byte_en;
   word_t     data_wdata;

   //////////////////////////////////////////////////
   // Stores

   dcache_tag_store u_tag_store (
      .clk            (clk),
      .reset          (reset),
      .i_index        (lookup_index),
      .i_tag          (lookup_tag),
      .i_touch        (touch),
      .i_touch_way    (touch_way),
      .i_set_dirty    (set_dirty),
      .i_fill         (fill),
      .o_hit_way      (hit_way),
      .o_victim_way   (victim_way),
      .o_victim_dirty (victim_dirty),
      .o_victim_tag   (victim_tag)
   );

   dcache_data_store u_data_store (
      .clk        (clk),
      .i_way      (data_way),
      .i_index    (lookup_index),
      .i_word_sel (word_sel),
      .i_we       (data_we),
      .i_byte_en  (byte_en),
      .i_wdata    (data_wdata),
      .o_rdata    (store_rdata)
   );

   //////////////////////////////////////////////////
   // Controller, with CPU and memory ports by name

   dcache_ctrl u_ctrl (
      .*,
      .o_lookup_index (lookup_index),
      .o_lookup_tag   (lookup_tag),
      .i_hit_way      (hit_way),
      .i_victim_way   (victim_way),
      .i_victim_dirty (victim_dirty),
      .i_victim_tag   (victim_tag),
      .i_store_rdata  (store_rdata),
      .o_touch        (touch),
      .o_touch_way    (touch_way),
      .o_set_dirty    (set_dirty),
      .o_fill         (fill),
      .o_data_way     (data_way),
      .o_word_sel     (word_sel),
      .o_data_we      (data_we),
      .o_byte_en      (byte_en),
      .o_data_wdata   (data_wdata)
   );

endmodule

// ==== test/dcache_patterns.txt ====
// op addr wdata byte_en expected; op 1 write, 2 read hit, 3 read miss without writeback,
// 4 read miss with writeback where wdata holds the victim line address
// Read miss, then a hit in the same line
3 00001004 00000000 0 a5a51004
2 0000101c 00000000 0 a5a5101c
// Partial stores on a hit and on a miss
1 00001008 11223344 5 00000000
2 00001008 00000000 0 a5221044
1 0000100c deadbeef 8 00000000
2 0000100c 00000000 0 dea5100c
1 00007010 0000beef 3 00000000
2 00007010 00000000 0 a5a5beef
// Set 0x10 with A, B and C; A dirty, C evicts B, B evicts A
3 00010200 00000000 0 a5a40200
3 00020204 00000000 0 a5a70204
1 00010200 cafef00d f 00000000
3 00030208 00000000 0 a5a60208
4 00020204 00010200 0 a5a70204
3 00010200 00000000 0 cafef00d
2 00010204 00000000 0 a5a40204
// Set 0x21 with D, E, D, then F; F evicts E
3 00040420 00000000 0 a5a10420
3 00050424 00000000 0 a5a00424
2 00040428 00000000 0 a5a10428
3 0006042c 00000000 0 a5a3042c
2 0004043c 00000000 0 a5a1043c
3 00050420 00000000 0 a5a00420

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen (
   input  logic i_restart,
   output logic clk,
   output logic reset
);

   int reset_cycles = 0;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Reset holds for 16 rising edges, and again after each restart
   always @(posedge clk) begin
      if (i_restart) begin
         reset_cycles <= 0;
      end else if (reset_cycles < 16) begin
         reset_cycles <= reset_cycles + 1;
      end
   end

   assign reset = reset_cycles < 16;

endmodule

// ==== test/tb_dcache.sv ====
`include "dcache_params.svh"

module tb_dcache;

   import dcache_addr_pkg::*;

   localparam int max_patterns       = 64;
   localparam int pattern_cols       = 5;
   localparam int cycles_per_pattern = 200;

   // Operation codes of the pattern file
   localparam logic [31:0] op_write     = 32'd1;
   localparam logic [31:0] op_read_hit  = 32'd2;
   localparam logic [31:0] op_read_miss = 32'd3;
   localparam logic [31:0] op_read_wb   = 32'd4;

   logic     clk;
   logic     reset;
   logic     restart;
   logic     i_req_valid;
   logic     i_req_write;
   addr_t    i_req_addr;
   word_t    i_req_wdata;
   byte_en_t i_req_byte_en;
   logic     o_req_ready;
   logic     o_resp_valid;
   word_t    o_resp_rdata;
   logic     o_ar_valid;
   logic     i_ar_ready = 1'b0;
   addr_t    o_ar_addr;
   logic     i_r_valid  = 1'b0;
   logic     o_r_ready;
   word_t    i_r_data   = '0;
   logic     i_r_last   = 1'b0;
   logic     o_aw_valid;
   logic     i_aw_ready = 1'b0;
   addr_t    o_aw_addr;
   logic     o_w_valid;
   logic     i_w_ready  = 1'b0;
   word_t    o_w_data;
   logic     o_w_last;
   logic     i_b_valid  = 1'b0;
   logic     o_b_ready;

   // Memory model state
   word_t    mem_store [addr_t];
   logic     stall_en  = 1'b0;
   int       seed      = 32'h1e8c;
   logic     rd_active = 1'b0;
   logic     r_hold    = 1'b0;
   addr_t    rd_addr   = '0;
   int       rd_beat   = 0;
   logic     wr_active = 1'b0;
   addr_t    wr_addr   = '0;
   int       wr_beat   = 0;
   logic     b_pending = 1'b0;
   int       ar_count  = 0;
   int       aw_count  = 0;
   int       w_count   = 0;
   int       wb_errors = 0;
   addr_t    last_ar_addr = '0;
   addr_t    last_aw_addr = '0;

   logic [31:0] patterns [max_patterns * pattern_cols];
   int          num_patterns = 0;
   int          errors       = 0;
   int          tests_failed = 0;

   tb_clock_gen u_clock_gen (
      .i_restart (restart),
      .clk       (clk),
      .reset     (reset)
   );

   dcache_top UUT (.*);

   //////////////////////////////////////////////////
   // AXI memory model

   // Untouched words follow the address rule
   function automatic word_t mem_read(addr_t addr);
      if (mem_store.exists(addr)) begin
         return mem_store[addr];
      end
      return addr ^ 32'hA5A50000;
   endfunction

   // One cycle in four stalls while stalls are on
   function automatic logic pick_stall();
      return stall_en && (($random(seed) & 3) == 0);
   endfunction

   always @(negedge clk) begin
      if (reset) begin
         i_ar_ready = 1'b0;
         i_r_valid  = 1'b0;
         i_r_last   = 1'b0;
         i_aw_ready = 1'b0;
         i_w_ready  = 1'b0;
         i_b_valid  = 1'b0;
         rd_active  = 1'b0;
         r_hold     = 1'b0;
         wr_active  = 1'b0;
         b_pending  = 1'b0;
         mem_store.delete();
      end else begin
         // Write response, held once raised
         i_b_valid = b_pending && (i_b_valid || !pick_stall());
         if (i_b_valid && o_b_ready) begin
            b_pending = 1'b0;
         end

         i_w_ready = wr_active && !pick_stall();
         if (o_w_valid && i_w_ready) begin
            assert (o_w_last == (wr_beat == `DC_LINE_WORDS - 1)) else begin
               $display("Fail at %0t: o_w_last = %b, expected %b", $time, o_w_last,
                        wr_beat == `DC_LINE_WORDS - 1);
               wb_errors++;
            end
            mem_store[wr_addr + addr_t'(4 * wr_beat)] = o_w_data;
            wr_beat++;
            w_count++;
            if (wr_beat == `DC_LINE_WORDS) begin
               wr_active = 1'b0;
               b_pending = 1'b1;
            end
         end

         i_aw_ready = !wr_active && !b_pending && !pick_stall();
         if (o_aw_valid && i_aw_ready) begin
            wr_active    = 1'b1;
            wr_addr      = o_aw_addr;
            wr_beat      = 0;
            last_aw_addr = o_aw_addr;
            aw_count++;
         end

         // Read data beats count up from the line base
         i_r_valid = rd_active && (r_hold || !pick_stall());
         i_r_data  = mem_read(rd_addr + addr_t'(4 * rd_beat));
         i_r_last  = rd_beat == `DC_LINE_WORDS - 1;
         r_hold    = i_r_valid && !o_r_ready;
         if (i_r_valid && o_r_ready) begin
            rd_beat++;
            rd_active = !i_r_last;
         end

         i_ar_ready = !rd_active && !pick_stall();
         if (o_ar_valid && i_ar_ready) begin
            rd_active    = 1'b1;
            rd_addr      = o_ar_addr;
            rd_beat      = 0;
            last_ar_addr = o_ar_addr;
            ar_count++;
         end
      end
   end

   //////////////////////////////////////////////////
   // Patterns and checks

   task automatic load_patterns();
      foreach (patterns[i]) begin
         patterns[i] = '1;
      end
      $readmemh("test/dcache_patterns.txt", patterns);
      while (num_patterns < max_patterns && patterns[num_patterns * pattern_cols] != '1) begin
         num_patterns++;
      end
      assert (num_patterns > 0) else begin
         $display("Error: no patterns were read from test/dcache_patterns.txt");
         errors++;
      end
   endtask

   task automatic run_pattern(int run, int index);
      logic [31:0] op;
      addr_t       addr;
      word_t       expected;
      int          latency;
      int          errors_before;
      int          ar_before;
      int          aw_before;
      int          w_before;
      op            = patterns[index * pattern_cols];
      addr          = patterns[index * pattern_cols + 1];
      expected      = patterns[index * pattern_cols + 4];
      errors_before = errors + wb_errors;
      ar_before     = ar_count;
      aw_before     = aw_count;
      w_before      = w_count;

      while (!o_req_ready) begin
         @(negedge clk);
      end
      i_req_valid   = 1'b1;
      i_req_write   = (op == op_write);
      i_req_addr    = addr;
      i_req_wdata   = patterns[index * pattern_cols + 2];
      i_req_byte_en = byte_en_t'(patterns[index * pattern_cols + 3]);
      @(negedge clk);
      i_req_valid = 1'b0;
      latency     = 1;

      // The cache stays busy until its response
      forever begin
         assert (!o_req_ready) else begin
            $display("Error at %0t: o_req_ready rose before the response", $time);
            errors++;
         end
         if (o_resp_valid) begin
            break;
         end
         @(negedge clk);
         latency++;
      end

      if (op != op_write) begin
         assert (o_resp_rdata == expected) else begin
            $display("Fail at %0t: o_resp_rdata = %h, expected %h", $time, o_resp_rdata,
                     expected);
            errors++;
         end
      end
      if (op == op_read_hit) begin
         assert (latency == 1) else begin
            $display("Error at %0t: hit at %h took %0d cycles, not one", $time, addr, latency);
            errors++;
         end
      end
      if (op == op_read_miss || op == op_read_wb) begin
         assert (ar_count == ar_before + 1 && last_ar_addr == (addr & ~addr_t'(32'h1f)))
         else begin
            $display("Error at %0t: miss at %h did not read its line in one burst", $time, addr);
            errors++;
         end
      end
      if (op == op_read_miss) begin
         assert (aw_count == aw_before) else begin
            $display("Error at %0t: clean miss at %h wrote a line back", $time, addr);
            errors++;
         end
      end
      if (op == op_read_wb) begin
         assert (aw_count == aw_before + 1) else begin
            $display("Error at %0t: dirty miss at %h wrote no line back", $time, addr);
            errors++;
         end
         assert (last_aw_addr == patterns[index * pattern_cols + 2]) else begin
            $display("Fail at %0t: o_aw_addr = %h, expected %h", $time, last_aw_addr,
                     patterns[index * pattern_cols + 2]);
            errors++;
         end
         assert (w_count == w_before + `DC_LINE_WORDS) else begin
            $display("Error at %0t: writeback had %0d beats", $time, w_count - w_before);
            errors++;
         end
      end

      if (errors + wb_errors != errors_before) begin
         tests_failed++;
      end
      $display("Run %0d pattern %0d at %h, %0d cycles: %s", run, index, addr, latency,
               (errors + wb_errors == errors_before) ? "ok" : "mismatch");
   endtask

   initial begin
      restart       = 1'b0;
      i_req_valid   = 1'b0;
      i_req_write   = 1'b0;
      i_req_addr    = '0;
      i_req_wdata   = '0;
      i_req_byte_en = '0;
      load_patterns();

      // Second run repeats everything from reset with memory stalls
      for (int run = 0; run < 2; run++) begin
         stall_en = (run == 1);
         if (run == 1) begin
            @(negedge clk);
            restart = 1'b1;
            @(negedge clk);
            restart = 1'b0;
         end
         @(negedge clk);
         while (reset) begin
            @(negedge clk);
         end
         for (int p = 0; p < num_patterns; p++) begin
            run_pattern(run, p);
         end
      end

      errors = errors + wb_errors;
      $display("%0d tests run, %0d failed, %0d errors", 2 * num_patterns, tests_failed, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      wait (num_patterns > 0);
      repeat (2 * num_patterns * cycles_per_pattern + 64) begin
         @(posedge clk);
      end
      $display("Error at %0t: watchdog expired, a request never finished", $time);
      $display("Test failed");
      $finish;
   end

endmodule
